//--- common/exe_params.svh
`ifndef EXE_PARAMS_SVH
`define EXE_PARAMS_SVH

// operand and result width
`define EXE_DATA_W 32

// tag width, bounds the operations in flight
`define EXE_TAG_W 4

// one restoring step per quotient bit
`define EXE_DIV_STEPS `EXE_DATA_W

`endif

//--- common/exe_pkg.sv
`default_nettype none

package exe_pkg;

  typedef enum logic [4:0] {
    op_add,    // add
    op_sub,    // subtract
    op_slt,    // set if less, signed
    op_sltu,   // set if less, unsigned
    op_and,
    op_nor,
    op_or,
    op_xor,
    op_sll,    // shift left logical
    op_srl,    // shift right logical
    op_sra,    // shift right arithmetic
    op_lui,    // load upper immediate
    op_mul,    // low word of product
    op_mulh,   // high word, signed
    op_mulhu,  // high word, unsigned
    op_div,
    op_divu,
    op_mod,
    op_modu
  } alu_op_t;

  // requesters on the writeback bus, in rising grant priority
  typedef enum logic [1:0] {
    unit_alu,
    unit_mul,
    unit_div
  } unit_t;

  typedef enum logic [1:0] {
    div_idle,
    div_run,
    div_done
  } div_state_t;

  // which execution unit owns an opcode
  function automatic unit_t unit_of(alu_op_t op);
    case (op)
      op_mul, op_mulh, op_mulhu:        return unit_mul;
      op_div, op_divu, op_mod, op_modu: return unit_div;
      default:                          return unit_alu;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- common/exe_issue_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "exe_params.svh"

// one issued operation, broadcast to all three units
interface exe_issue_if;

  logic                    valid;  // single-cycle issue strobe
  exe_pkg::alu_op_t        op;
  logic [`EXE_DATA_W-1:0]  src1;
  logic [`EXE_DATA_W-1:0]  src2;
  logic [`EXE_TAG_W-1:0]   tag;

  modport unit (
    input valid,
    input op,
    input src1,
    input src2,
    input tag
  );

endinterface

`default_nettype wire

//--- common/exe_result_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "exe_params.svh"

// one unit's pending result toward the writeback arbiter
interface exe_result_if;

  logic                    req;    // held until granted
  logic [`EXE_DATA_W-1:0]  data;
  logic [`EXE_TAG_W-1:0]   tag;
  logic                    busy;   // no new op of this class next cycle
  logic                    grant;

  modport src (
    output req,
    output data,
    output tag,
    output busy,
    input  grant
  );

  modport arb (
    input  req,
    input  data,
    input  tag,
    input  busy,
    output grant
  );

endinterface

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "exe_params.svh"

module alu (
  input  logic       clk,
  input  logic       rst,
  exe_issue_if.unit  issue,
  exe_result_if.src  res
);

  localparam int W   = `EXE_DATA_W;
  localparam int SHW = $clog2(W);

  logic          take;
  logic          use_sub;  // subtract and both compares
  logic [W-1:0]  adder_b;
  logic [W-1:0]  adder_sum;
  logic          adder_cout;
  logic          slt_bit;
  logic [2*W-1:0] sr_wide;
  logic [W-1:0]  result;

  logic          slot_full;
  logic [W-1:0]  slot_data;
  logic [`EXE_TAG_W-1:0] slot_tag;

  assign take = issue.valid && (exe_pkg::unit_of(issue.op) == exe_pkg::unit_alu);

  assign use_sub = (issue.op == exe_pkg::op_sub) || (issue.op == exe_pkg::op_slt) ||
                   (issue.op == exe_pkg::op_sltu);

  // one adder, src2 inverted plus carry-in for a - b
  assign adder_b = use_sub ? ~issue.src2 : issue.src2;
  assign {adder_cout, adder_sum} = {1'b0, issue.src1} + {1'b0, adder_b} + {{W{1'b0}}, use_sub};

  // negative vs positive, else sign of the difference
  assign slt_bit = (issue.src1[W-1] & ~issue.src2[W-1]) |
                   ((issue.src1[W-1] ~^ issue.src2[W-1]) & adder_sum[W-1]);

  // upper half fills with sign for sra
  assign sr_wide = {{W{(issue.op == exe_pkg::op_sra) & issue.src1[W-1]}}, issue.src1}
                   >> issue.src2[SHW-1:0];

  always_comb begin
    case (issue.op)
      exe_pkg::op_add,
      exe_pkg::op_sub:  result = adder_sum;
      exe_pkg::op_slt:  result = {{(W-1){1'b0}}, slt_bit};
      exe_pkg::op_sltu: result = {{(W-1){1'b0}}, ~adder_cout};  // borrow out
      exe_pkg::op_and:  result = issue.src1 & issue.src2;
      exe_pkg::op_nor:  result = ~(issue.src1 | issue.src2);
      exe_pkg::op_or:   result = issue.src1 | issue.src2;
      exe_pkg::op_xor:  result = issue.src1 ^ issue.src2;
      exe_pkg::op_sll:  result = issue.src1 << issue.src2[SHW-1:0];
      exe_pkg::op_srl,
      exe_pkg::op_sra:  result = sr_wide[W-1:0];
      exe_pkg::op_lui:  result = issue.src2;  // immediate arrives pre-shifted
      default:          result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_full <= 1'b0;
    end else if (take) begin
      slot_full <= 1'b1;
    end else if (res.grant) begin
      slot_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      slot_data <= result;
      slot_tag  <= issue.tag;
    end
  end

  assign res.req  = slot_full;
  assign res.data = slot_data;
  assign res.tag  = slot_tag;
  assign res.busy = slot_full && !res.grant;

  // a pending entry must leave through the arbiter before the next op lands
  a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
    take |-> !(slot_full && !res.grant))
    else $error("alu result slot overwritten before grant");

endmodule

`default_nettype wire

//--- muldiv/mul_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "exe_params.svh"

module mul_unit (
  input  logic       clk,
  input  logic       rst,
  exe_issue_if.unit  issue,
  exe_result_if.src  res
);

  localparam int W = `EXE_DATA_W;

  logic                 take;
  logic                 advance;
  logic                 unsigned_op;
  logic signed [W:0]    a_ext;
  logic signed [W:0]    b_ext;
  logic signed [2*W+1:0] product;

  logic                 s1_valid;
  logic [2*W-1:0]       s1_prod;
  logic                 s1_high;  // return upper word
  logic [`EXE_TAG_W-1:0] s1_tag;

  logic                 s2_valid;
  logic [W-1:0]         s2_data;
  logic [`EXE_TAG_W-1:0] s2_tag;

  assign take        = issue.valid && (exe_pkg::unit_of(issue.op) == exe_pkg::unit_mul);
  assign unsigned_op = (issue.op == exe_pkg::op_mulhu);
  assign advance     = !s2_valid || res.grant;

  // 33-bit operands cover both signed and unsigned forms
  assign a_ext   = {issue.src1[W-1] & ~unsigned_op, issue.src1};
  assign b_ext   = {issue.src2[W-1] & ~unsigned_op, issue.src2};
  assign product = a_ext * b_ext;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (take) begin
        s1_valid <= 1'b1;
      end else if (advance) begin
        s1_valid <= 1'b0;
      end
      if (advance) begin
        s2_valid <= s1_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      s1_prod <= product[2*W-1:0];
      s1_high <= (issue.op != exe_pkg::op_mul);
      s1_tag  <= issue.tag;
    end
    if (advance) begin
      s2_data <= s1_high ? s1_prod[2*W-1:W] : s1_prod[W-1:0];
      s2_tag  <= s1_tag;
    end
  end

  assign res.req  = s2_valid;
  assign res.data = s2_data;
  assign res.tag  = s2_tag;
  assign res.busy = s2_valid && !res.grant && s1_valid;  // both stages stuck

endmodule

`default_nettype wire

//--- muldiv/div_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "exe_params.svh"

module div_unit (
  input  logic       clk,
  input  logic       rst,
  exe_issue_if.unit  issue,
  exe_result_if.src  res
);

  localparam int W   = `EXE_DATA_W;
  localparam int CNW = $clog2(`EXE_DIV_STEPS + 1);

  exe_pkg::div_state_t state;

  logic            take;
  logic            signed_op;
  logic [W-1:0]    mag_a;
  logic [W-1:0]    mag_b;
  logic [W:0]      shifted;
  logic [W:0]      trial;
  logic [W-1:0]    q_out;
  logic [W-1:0]    r_out;

  logic [CNW-1:0]  step_cnt;
  logic [W-1:0]    quot;     // dividend shifts out, quotient shifts in
  logic [W-1:0]    rem;
  logic [W-1:0]    dvsr;
  logic            neg_q;
  logic            neg_r;
  logic            want_rem;
  logic            zero_div;
  logic [`EXE_TAG_W-1:0] tag_q;

  assign take      = issue.valid && (exe_pkg::unit_of(issue.op) == exe_pkg::unit_div);
  assign signed_op = (issue.op == exe_pkg::op_div) || (issue.op == exe_pkg::op_mod);

  assign mag_a = (signed_op && issue.src1[W-1]) ? -issue.src1 : issue.src1;
  assign mag_b = (signed_op && issue.src2[W-1]) ? -issue.src2 : issue.src2;

  // restoring step, bit W of the difference is the borrow
  assign shifted = {rem, quot[W-1]};
  assign trial   = shifted - {1'b0, dvsr};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= exe_pkg::div_idle;
    end else begin
      case (state)
        exe_pkg::div_idle: if (take) state <= exe_pkg::div_run;
        exe_pkg::div_run:  if (step_cnt == CNW'(`EXE_DIV_STEPS - 1)) state <= exe_pkg::div_done;
        exe_pkg::div_done: if (res.grant) state <= exe_pkg::div_idle;
        default:           state <= exe_pkg::div_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == exe_pkg::div_idle && take) begin
      step_cnt <= '0;
      quot     <= mag_a;
      rem      <= '0;
      dvsr     <= mag_b;
      neg_q    <= signed_op && (issue.src1[W-1] ^ issue.src2[W-1]);
      neg_r    <= signed_op && issue.src1[W-1];  // remainder follows dividend
      want_rem <= (issue.op == exe_pkg::op_mod) || (issue.op == exe_pkg::op_modu);
      zero_div <= (issue.src2 == '0);
      tag_q    <= issue.tag;
    end else if (state == exe_pkg::div_run) begin
      step_cnt <= step_cnt + 1'b1;
      if (!trial[W]) begin
        rem  <= trial[W-1:0];
        quot <= {quot[W-2:0], 1'b1};
      end else begin
        rem  <= shifted[W-1:0];
        quot <= {quot[W-2:0], 1'b0};
      end
    end
  end

  // rem ends equal to |dividend| on a zero divisor, so its sign fix restores it
  assign q_out = zero_div ? '1 : (neg_q ? -quot : quot);
  assign r_out = neg_r ? -rem : rem;

  assign res.req  = (state == exe_pkg::div_done);
  assign res.data = want_rem ? r_out : q_out;
  assign res.tag  = tag_q;
  assign res.busy = (state != exe_pkg::div_idle);

  // issue must honour the stall raised while a divide is in progress
  a_div_idle_issue: assert property (@(posedge clk) disable iff (rst)
    take |-> state == exe_pkg::div_idle)
    else $error("divide issued while divider busy");

endmodule

`default_nettype wire

//--- hw/wb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "exe_params.svh"

module wb_arbiter (
  exe_result_if.arb              alu_res,
  exe_result_if.arb              mul_res,
  exe_result_if.arb              div_res,
  output logic                   issue_stall,
  output logic                   result_valid,
  output logic [`EXE_TAG_W-1:0]  result_tag,
  output logic [`EXE_DATA_W-1:0] result_data
);

  exe_pkg::unit_t winner;
  logic           any_req;

  assign any_req = alu_res.req || mul_res.req || div_res.req;

  // fixed priority, div first then mul
  always_comb begin
    winner = exe_pkg::unit_alu;
    if (div_res.req) begin
      winner = exe_pkg::unit_div;
    end else if (mul_res.req) begin
      winner = exe_pkg::unit_mul;
    end
  end

  assign alu_res.grant = any_req && (winner == exe_pkg::unit_alu);
  assign mul_res.grant = any_req && (winner == exe_pkg::unit_mul);
  assign div_res.grant = any_req && (winner == exe_pkg::unit_div);

  always_comb begin
    case (winner)
      exe_pkg::unit_div: {result_tag, result_data} = {div_res.tag, div_res.data};
      exe_pkg::unit_mul: {result_tag, result_data} = {mul_res.tag, mul_res.data};
      default:           {result_tag, result_data} = {alu_res.tag, alu_res.data};
    endcase
  end

  assign result_valid = any_req;
  assign issue_stall  = alu_res.busy || mul_res.busy || div_res.busy;

  // grants are one-hot and only ever reach a requesting unit
  always_comb begin
    assert ($onehot0({alu_res.grant, mul_res.grant, div_res.grant}))
      else $error("writeback grants not one-hot");
    assert (!(alu_res.grant && !alu_res.req) && !(mul_res.grant && !mul_res.req) &&
            !(div_res.grant && !div_res.req))
      else $error("grant to an idle unit");
  end

endmodule

`default_nettype wire

//--- hw/exe_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "exe_params.svh"

module exe_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   issue_valid,
  input  exe_pkg::alu_op_t       issue_op,
  input  logic [`EXE_DATA_W-1:0] issue_src1,
  input  logic [`EXE_DATA_W-1:0] issue_src2,
  input  logic [`EXE_TAG_W-1:0]  issue_tag,
  output logic                   issue_stall,
  output logic                   result_valid,
  output logic [`EXE_TAG_W-1:0]  result_tag,
  output logic [`EXE_DATA_W-1:0] result_data
);

  exe_issue_if  issue_bus ();
  exe_result_if alu_bus ();
  exe_result_if mul_bus ();
  exe_result_if div_bus ();

  // same operation broadcast, each unit picks its own class
  assign issue_bus.valid = issue_valid;
  assign issue_bus.op    = issue_op;
  assign issue_bus.src1  = issue_src1;
  assign issue_bus.src2  = issue_src2;
  assign issue_bus.tag   = issue_tag;

  alu u_alu (
    .clk   (clk),
    .rst   (rst),
    .issue (issue_bus),
    .res   (alu_bus)
  );

  mul_unit u_mul (
    .clk   (clk),
    .rst   (rst),
    .issue (issue_bus),
    .res   (mul_bus)
  );

  div_unit u_div (
    .clk   (clk),
    .rst   (rst),
    .issue (issue_bus),
    .res   (div_bus)
  );

  wb_arbiter u_arb (
    .alu_res      (alu_bus),
    .mul_res      (mul_bus),
    .div_res      (div_bus),
    .issue_stall  (issue_stall),
    .result_valid (result_valid),
    .result_tag   (result_tag),
    .result_data  (result_data)
  );

endmodule

`default_nettype wire

//--- test/exe_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "exe_params.svh"

module exe_unit_tb;

  localparam int W          = `EXE_DATA_W;
  localparam int TAGS       = 1 << `EXE_TAG_W;
  localparam int WAIT_LIMIT = 200;  // cycles per wait loop
  localparam logic [W-1:0] MIN_INT = {1'b1, {(W-1){1'b0}}};

  logic                  clk;
  logic                  rst;
  logic                  issue_valid;
  exe_pkg::alu_op_t      issue_op;
  logic [W-1:0]          issue_src1;
  logic [W-1:0]          issue_src2;
  logic [`EXE_TAG_W-1:0] issue_tag;
  logic                  issue_stall;
  logic                  result_valid;
  logic [`EXE_TAG_W-1:0] result_tag;
  logic [W-1:0]          result_data;

  logic                  pending [TAGS];    // tag scoreboard
  logic [W-1:0]          exp_data [TAGS];
  int                    ret_order [TAGS];  // position in the return stream
  int                    ret_count;
  logic [`EXE_TAG_W-1:0] next_tag;
  logic [31:0]           lcg_state;
  logic                  timed_out;
  int                    checks;
  int                    errors;
  int                    test_err_base;

  exe_unit u_dut (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .issue_src1   (issue_src1),
    .issue_src2   (issue_src2),
    .issue_tag    (issue_tag),
    .issue_stall  (issue_stall),
    .result_valid (result_valid),
    .result_tag   (result_tag),
    .result_data  (result_data)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // expected result straight from the operation rules
  function automatic logic [W-1:0] ref_result(exe_pkg::alu_op_t op, logic [W-1:0] a,
                                              logic [W-1:0] b);
    logic signed [W-1:0] sa;
    logic signed [W-1:0] sb;
    logic [2*W-1:0]      sp;
    logic [2*W-1:0]      up;
    sa = a;
    sb = b;
    sp = {{W{a[W-1]}}, a} * {{W{b[W-1]}}, b};  // low 2W bits of the signed product
    up = {{W{1'b0}}, a} * {{W{1'b0}}, b};
    case (op)
      exe_pkg::op_add:   return a + b;
      exe_pkg::op_sub:   return a - b;
      exe_pkg::op_slt:   return {{(W-1){1'b0}}, sa < sb};
      exe_pkg::op_sltu:  return {{(W-1){1'b0}}, a < b};
      exe_pkg::op_and:   return a & b;
      exe_pkg::op_nor:   return ~(a | b);
      exe_pkg::op_or:    return a | b;
      exe_pkg::op_xor:   return a ^ b;
      exe_pkg::op_sll:   return a << b[4:0];
      exe_pkg::op_srl:   return a >> b[4:0];
      exe_pkg::op_sra:   return sa >>> b[4:0];
      exe_pkg::op_lui:   return b;  // immediate comes in already shifted
      exe_pkg::op_mul:   return sp[W-1:0];
      exe_pkg::op_mulh:  return sp[2*W-1:W];
      exe_pkg::op_mulhu: return up[2*W-1:W];
      exe_pkg::op_div: begin
        if (b == '0) return '1;
        else if (a == MIN_INT && b == '1) return MIN_INT;
        else return sa / sb;
      end
      exe_pkg::op_mod: begin
        if (b == '0) return a;
        else if (a == MIN_INT && b == '1) return '0;
        else return sa % sb;
      end
      exe_pkg::op_divu:  return (b == '0) ? '1 : a / b;
      exe_pkg::op_modu:  return (b == '0) ? a : a % b;
      default:           return '0;
    endcase
  endfunction

  function automatic int in_flight();
    int n;
    n = 0;
    for (int t = 0; t < TAGS; t++) begin
      if (pending[t]) n++;
    end
    return n;
  endfunction

  // later waits fall straight through once one has expired
  task automatic note_timeout(input string why);
    errors++;
    timed_out = 1'b1;
    $display("%s at %0t ns", why, $time);
  endtask

  task automatic finish_test(input string name);
    $display("test %s done with %0d errors", name, errors - test_err_base);
    test_err_base = errors;
  endtask

  // called right after a rising edge
  task automatic drive_issue(input exe_pkg::alu_op_t op, input logic [W-1:0] a,
                             input logic [W-1:0] b);
    issue_valid <= 1'b1;
    issue_op    <= op;
    issue_src1  <= a;
    issue_src2  <= b;
    issue_tag   <= next_tag;
    exp_data[next_tag] = ref_result(op, a, b);
    pending[next_tag]  = 1'b1;
    next_tag = next_tag + 1'b1;
  endtask

  // stall low in an idle cycle stays low in the next one
  task automatic wait_issue_slot();
    int   waited;
    logic stall_seen;
    waited     = 0;
    stall_seen = 1'b1;
    while ((stall_seen || pending[next_tag]) && waited < WAIT_LIMIT && !timed_out) begin
      @(negedge clk);
      stall_seen = issue_stall;
      @(posedge clk);
      waited++;
    end
    if (!timed_out && (stall_seen || pending[next_tag])) begin
      note_timeout("issue_stall or a busy tag never cleared");
    end
  endtask

  task automatic send(input exe_pkg::alu_op_t op, input logic [W-1:0] a,
                      input logic [W-1:0] b);
    wait_issue_slot();
    drive_issue(op, a, b);
    @(posedge clk);
    issue_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (in_flight() != 0 && waited < WAIT_LIMIT && !timed_out) begin
      @(posedge clk);
      waited++;
    end
    if (!timed_out && in_flight() != 0) begin
      note_timeout("results still missing after the drain timeout");
    end
  endtask

  // every writeback pulse is matched against the scoreboard
  always @(negedge clk) begin
    if (!rst && result_valid === 1'b1) begin
      checks++;
      ret_count++;
      if (!pending[result_tag]) begin
        errors++;
        $display("result for tag %0d at %0t ns with no operation in flight", result_tag, $time);
      end else begin
        if (result_data !== exp_data[result_tag]) begin
          errors++;
          $display("error at %0t ns: result_data for tag %0d got %h expected %h",
                   $time, result_tag, result_data, exp_data[result_tag]);
        end
        pending[result_tag]   = 1'b0;
        ret_order[result_tag] = ret_count;
      end
    end
  end

  initial begin
    int               div_tag;
    int               alu_tag;
    logic [31:0]      r;
    logic [W-1:0]     a;
    logic [W-1:0]     b;
    exe_pkg::alu_op_t op;
    logic [W-1:0]     div_a [6];
    logic [W-1:0]     div_b [6];
    div_a = '{32'hfffffff9, 32'd7, 32'd100, MIN_INT, MIN_INT, 32'd5};
    div_b = '{32'd2, 32'hfffffffe, 32'd7, 32'hffffffff, 32'd0, 32'd0};
    clk         = 1'b0;
    rst         = 1'b1;
    issue_valid = 1'b0;
    issue_op    = exe_pkg::op_add;
    issue_src1  = '0;
    issue_src2  = '0;
    issue_tag   = '0;
    next_tag    = '0;
    lcg_state   = 32'd53500;
    timed_out   = 1'b0;
    checks      = 0;
    errors      = 0;
    ret_count   = 0;
    for (int t = 0; t < TAGS; t++) begin
      pending[t]   = 1'b0;
      ret_order[t] = 0;
    end
    test_err_base = 0;

    repeat (8) @(posedge clk);
    rst <= 1'b0;

    repeat (6) begin
      @(negedge clk);
      checks += 2;
      if (issue_stall !== 1'b0) begin
        errors++;
        $display("error at %0t ns: issue_stall got %b expected 0", $time, issue_stall);
      end
      if (result_valid !== 1'b0) begin
        errors++;
        $display("error at %0t ns: result_valid got %b expected 0", $time, result_valid);
      end
    end
    finish_test("reset state");

    send(exe_pkg::op_add, 32'h7fffffff, 32'd1);
    send(exe_pkg::op_add, 32'hffffffff, 32'd1);
    send(exe_pkg::op_sub, MIN_INT, 32'd1);
    send(exe_pkg::op_sub, 32'd0, 32'd1);
    send(exe_pkg::op_slt, 32'hffffffff, 32'd1);
    send(exe_pkg::op_sltu, 32'hffffffff, 32'd1);
    send(exe_pkg::op_slt, 32'd1, MIN_INT);
    send(exe_pkg::op_sltu, 32'd1, MIN_INT);
    send(exe_pkg::op_sll, 32'h80000001, 32'd0);
    send(exe_pkg::op_sll, 32'h00000003, 32'd31);
    send(exe_pkg::op_srl, 32'h80000000, 32'd31);
    send(exe_pkg::op_sra, 32'h80000010, 32'd4);
    send(exe_pkg::op_sra, MIN_INT, 32'd31);
    send(exe_pkg::op_lui, 32'h0, 32'h12345000);
    send(exe_pkg::op_nor, 32'h0f0f0000, 32'h00f0000f);
    wait_drain();
    finish_test("alu corners");

    send(exe_pkg::op_mul, MIN_INT, MIN_INT);
    send(exe_pkg::op_mulh, MIN_INT, MIN_INT);
    send(exe_pkg::op_mulhu, MIN_INT, MIN_INT);
    send(exe_pkg::op_mulh, 32'hffffffff, 32'hffffffff);
    send(exe_pkg::op_mulhu, 32'hffffffff, 32'hffffffff);
    send(exe_pkg::op_mulh, 32'h7fffffff, MIN_INT);
    wait_drain();
    wait_issue_slot();
    drive_issue(exe_pkg::op_mul, 32'h12345678, 32'h9abcdef0);
    @(posedge clk);
    drive_issue(exe_pkg::op_mulhu, 32'hdeadbeef, 32'hcafef00d);  // second stage still empty
    @(posedge clk);
    issue_valid <= 1'b0;
    wait_drain();
    finish_test("multiplier");

    for (int i = 0; i < 6; i++) begin
      for (int k = 0; k < 4; k++) begin
        send(exe_pkg::alu_op_t'(exe_pkg::op_div + k), div_a[i], div_b[i]);
      end
    end
    wait_drain();
    finish_test("divider");

    // the ALU slot empties every cycle while the divider is still running
    wait_issue_slot();
    div_tag = next_tag;
    drive_issue(exe_pkg::op_div, 32'hfffff000, 32'd7);
    alu_tag = div_tag;
    repeat (4) begin
      @(posedge clk);
      issue_valid <= 1'b0;
      @(posedge clk);
      alu_tag = next_tag;
      a = lcg_next();
      drive_issue(exe_pkg::op_xor, a, 32'h5a5a5a5a);
    end
    @(posedge clk);
    issue_valid <= 1'b0;
    wait_drain();
    checks++;
    if (ret_order[div_tag] < ret_order[alu_tag]) begin
      errors++;
      $display("divide result came back before the ALU results issued after it");
    end
    finish_test("out of order");

    for (int n = 0; n < 300; n++) begin
      r  = lcg_next();
      op = exe_pkg::alu_op_t'(r[20:16] % 5'd19);
      a  = lcg_next();
      b  = lcg_next();
      if (r[3:0] == 4'd0) b = '0;  // zero divisor now and then
      else if (r[3:0] == 4'd1) b = '1;
      else if (r[3:0] == 4'd2) a = MIN_INT;
      send(op, a, b);
    end
    wait_drain();
    finish_test("random mix");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- exe_unit.f
+incdir+common
common/exe_pkg.sv
common/exe_issue_if.sv
common/exe_result_if.sv
hw/alu.sv
muldiv/mul_unit.sv
muldiv/div_unit.sv
hw/wb_arbiter.sv
hw/exe_unit.sv
test/exe_unit_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module exe_unit_tb -f exe_unit.f
	./obj_dir/Vexe_unit_tb > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "Test failed" sim.log

clean:
	rm -rf obj_dir sim.log
